/* test/dut_trace.txt */
// idle cycles, instruction word, retire flag, rd, retire data, x4 after retire
// A line with idle ffffffff ends the trace.
00000002 12300213 1 04 00000123 00000123
00000000 ffb00093 1 01 fffffffb 00000123
00000000 00300113 1 02 00000003 00000123
00000000 002081b3 1 03 fffffffe 00000123
00000001 401102b3 1 05 00000008 00000123
00000000 0020e333 1 06 fffffffb 00000123
00000000 0040f3b3 1 07 00000123 00000123
00000000 0020c433 1 08 fffffff8 00000123
00000000 002114b3 1 09 00000018 00000123
00000000 0020d533 1 0a 1fffffff 00000123
00000000 4020d5b3 1 0b ffffffff 00000123
00000000 0020a633 1 0c 00000001 00000123
00000000 0020b6b3 1 0d 00000000 00000123
00000000 0f00f713 1 0e 000000f0 00000123
00000000 f0016793 1 0f ffffff03 00000123
00000000 fff0c813 1 10 00000004 00000123
00000000 ffc0a893 1 11 00000001 00000123
00000000 fff13913 1 12 00000001 00000123
00000000 01e11993 1 13 c0000000 00000123
00000000 0049da13 1 14 0c000000 00000123
00000001 4049da93 1 15 fc000000 00000123
00000002 abcde237 1 04 abcde000 abcde000
00000001 76520213 1 04 abcde765 abcde765
00000000 00120013 1 00 abcde766 abcde765
00000000 00400b33 1 16 abcde765 abcde765
00000002 00112023 0 00 00000000 abcde765
00000000 002b0cb3 1 19 abcde768 abcde765
ffffffff 00000000 0 00 00000000 00000000

/* filelist.f */
logic/core_pkg.sv
logic/core_if.sv
logic/insn_decode.sv
logic/alu_execute.sv
logic/result_regfile.sv
logic/dut.sv
test/tb_dut.sv

/* Makefile */
# Verilator build and run of the core testbench.
TOP := tb_dut

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in sim.log"
	@echo "  clean  remove the build folder and the run log"

test:
	verilator --binary --assert --top-module $(TOP) -f filelist.f --Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_dut.sv */
`timescale 1ns/1ps

module tb_dut;
    import core_pkg::*;

    localparam int FIELDS    = 6;
    localparam int MAX_ITEMS = 64;
    localparam int DRAIN_MAX = 20;

    logic                 clk;
    logic                 i_arst_n;
    logic [XLEN-1:0]      i_ic_insn;
    logic                 i_ic_valid;
    logic [XLEN-1:0]      o_ic_pc;
    logic                 o_ic_en;
    logic                 o_retire_en;
    logic [REG_IDX_W-1:0] o_retire_rd;
    logic [XLEN-1:0]      o_retire_data;
    logic [XLEN-1:0]      o_sim_tp;

    logic [31:0] trace [0:511];

    // Expected outcome of the word now on the instruction port.
    logic        drv_ret;
    logic [31:0] drv_rd;
    logic [31:0] drv_data;
    logic [31:0] drv_tp;

    logic [31:0] exp_rd_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] exp_tp_q[$];
    int          exp_cyc_q[$];

    int          errors;
    int          n_items;
    int          cyc;
    int          run_cycles;
    int          pulses;
    int          drain;
    int          i;
    logic        tp_pend;
    logic [31:0] tp_exp;

    dut uut (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_ic_insn(i_ic_insn),
        .i_ic_valid(i_ic_valid),
        .o_ic_pc(o_ic_pc),
        .o_ic_en(o_ic_en),
        .o_retire_en(o_retire_en),
        .o_retire_rd(o_retire_rd),
        .o_retire_data(o_retire_data),
        .o_sim_tp(o_sim_tp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] trace_word(input int item, input int field);
        return trace[9'(item * FIELDS + field)];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Outputs settle well before the falling edge.
    always @(negedge clk) begin
        cyc++;
        if (!i_arst_n) begin
            check_value("o_ic_en", 32'(o_ic_en), 32'd0);
            check_value("o_ic_pc", o_ic_pc, 32'd0);
            check_value("o_retire_en", 32'(o_retire_en), 32'd0);
        end else begin
            check_value("o_ic_en", 32'(o_ic_en), (run_cycles > 0) ? 32'd1 : 32'd0);
            run_cycles++;
            check_value("o_ic_pc", o_ic_pc, 32'(pulses * PC_STEP));
            // x4 is written on the edge after its retire is seen.
            if (tp_pend) begin
                check_value("o_sim_tp", o_sim_tp, tp_exp);
                tp_pend = 1'b0;
            end
            if (o_retire_en) begin
                if (exp_rd_q.size() == 0) begin
                    errors++;
                    $display("Unexpected retire at %0t with nothing in flight", $time);
                end else begin
                    check_value("retire latency", 32'(cyc - exp_cyc_q.pop_front()), 32'd2);
                    check_value("o_retire_rd", 32'(o_retire_rd), exp_rd_q.pop_front());
                    check_value("o_retire_data", o_retire_data, exp_data_q.pop_front());
                    tp_exp  = exp_tp_q.pop_front();
                    tp_pend = 1'b1;
                end
            end
            if (i_ic_valid) begin
                pulses++;
                if (drv_ret) begin
                    exp_rd_q.push_back(drv_rd);
                    exp_data_q.push_back(drv_data);
                    exp_tp_q.push_back(drv_tp);
                    exp_cyc_q.push_back(cyc);
                end
            end
        end
    end

    initial begin
        clk        = 1'b0;
        i_arst_n   = 1'b0;
        i_ic_valid = 1'b0;
        i_ic_insn  = '0;
        drv_ret    = 1'b0;
        drv_rd     = '0;
        drv_data   = '0;
        drv_tp     = '0;
        errors     = 0;
        n_items    = 0;
        cyc        = 0;
        run_cycles = 0;
        pulses     = 0;
        tp_pend    = 1'b0;
        tp_exp     = '0;
        for (i = 0; i < 512; i++) begin
            trace[i] = '0;
        end
        $readmemh("test/dut_trace.txt", trace);
        while (n_items < MAX_ITEMS && trace_word(n_items, 0) != 32'hFFFFFFFF) begin
            n_items++;
        end
        if (n_items == MAX_ITEMS || n_items == 0) begin
            errors++;
            $display("Trace file is empty or has no end marker");
            n_items = 0;
        end

        repeat (8) @(posedge clk);
        i_arst_n <= 1'b1;

        for (i = 0; i < n_items; i++) begin
            repeat (trace_word(i, 0)) begin
                @(posedge clk);
                i_ic_valid <= 1'b0;
            end
            @(posedge clk);
            i_ic_valid <= 1'b1;
            i_ic_insn  <= trace_word(i, 1);
            drv_ret    <= (trace_word(i, 2) != 0);
            drv_rd     <= trace_word(i, 3);
            drv_data   <= trace_word(i, 4);
            drv_tp     <= trace_word(i, 5);
        end
        @(posedge clk);
        i_ic_valid <= 1'b0;

        drain = 0;
        while ((exp_rd_q.size() != 0 || tp_pend) && drain < DRAIN_MAX) begin
            @(posedge clk);
            drain++;
        end
        if (exp_rd_q.size() != 0 || tp_pend) begin
            errors++;
            $display("Timed out with %0d retires still missing", exp_rd_q.size());
        end
        // A few quiet cycles catch stray retires.
        repeat (4) @(posedge clk);

        $display("Run finished: %0d errors over %0d trace items", errors, n_items);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* logic/dut.sv */
`timescale 1ns/1ps

module dut (
    input  logic                          clk,
    input  logic                          i_arst_n,

    // Instruction port.
    input  logic [core_pkg::XLEN-1:0]      i_ic_insn,
    input  logic                          i_ic_valid,
    output logic [core_pkg::XLEN-1:0]      o_ic_pc,
    output logic                          o_ic_en,

    // Retire and test point.
    output logic                          o_retire_en,
    output logic [core_pkg::REG_IDX_W-1:0] o_retire_rd,
    output logic [core_pkg::XLEN-1:0]      o_retire_data,
    output logic [core_pkg::XLEN-1:0]      o_sim_tp
);

    dec_exe_if dx ();
    exe_res_if er ();

    insn_decode insn_decode_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_ic_valid(i_ic_valid),
        .i_ic_insn(i_ic_insn),
        .o_ic_pc(o_ic_pc),
        .o_ic_en(o_ic_en),
        .dx(dx.dec),
        .er(er.dec)
    );

    alu_execute alu_execute_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .dx(dx.exe),
        .er(er.exe)
    );

    result_regfile result_regfile_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .er(er.res),
        .o_retire_en(o_retire_en),
        .o_retire_rd(o_retire_rd),
        .o_retire_data(o_retire_data),
        .o_sim_tp(o_sim_tp)
    );

endmodule

/* logic/result_regfile.sv */
`timescale 1ns/1ps

module result_regfile (
    input  logic                          clk,
    input  logic                          i_arst_n,
    exe_res_if.res                        er,
    output logic                          o_retire_en,
    output logic [core_pkg::REG_IDX_W-1:0] o_retire_rd,
    output logic [core_pkg::XLEN-1:0]      o_retire_data,
    output logic [core_pkg::XLEN-1:0]      o_sim_tp
);
    import core_pkg::*;

    // x0 has no storage.
    logic [XLEN-1:0] regs [1:REG_COUNT-1];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_IDX_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (er.valid && er.rd == idx) begin
            val = er.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        er.rdata1 = read_port(er.rs1);
        er.rdata2 = read_port(er.rs2);
    end

    always_ff @(posedge clk) begin
        if (er.valid && er.rd != '0) begin
            regs[er.rd] <= er.data;
        end
    end

    // Retire reports the value even for x0.
    assign o_retire_en   = er.valid;
    assign o_retire_rd   = er.rd;
    assign o_retire_data = er.data;

    assign o_sim_tp = regs[TP_REG];

    a_retire_written: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_retire_en && o_retire_rd != '0 |=> regs[$past(o_retire_rd)] == $past(o_retire_data))
        else $error("Retired value did not reach the register file.");

endmodule

/* logic/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
    input  logic  clk,
    input  logic  i_arst_n,
    dec_exe_if.exe dx,
    exe_res_if.exe er
);
    import core_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    assign shamt = dx.opb[4:0];

    always_comb begin
        case (dx.op)
            ALU_ADD:    result = dx.opa + dx.opb;
            ALU_SUB:    result = dx.opa - dx.opb;
            ALU_AND:    result = dx.opa & dx.opb;
            ALU_OR:     result = dx.opa | dx.opb;
            ALU_XOR:    result = dx.opa ^ dx.opb;
            ALU_SLL:    result = dx.opa << shamt;
            ALU_SRL:    result = dx.opa >> shamt;
            ALU_SRA:    result = $unsigned($signed(dx.opa) >>> shamt);
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(dx.opa) < $signed(dx.opb)};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, dx.opa < dx.opb};
            ALU_PASS_B: result = dx.opb;
            default:    result = '0;
        endcase
    end

    // Forward to decode for a dependent word one cycle behind.
    assign dx.fwd_valid = dx.valid;
    assign dx.fwd_rd    = dx.rd;
    assign dx.fwd_data  = result;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            er.valid <= 1'b0;
        end else begin
            er.valid <= dx.valid;
        end
    end

    always_ff @(posedge clk) begin
        er.rd   <= dx.rd;
        er.data <= result;
    end

    a_op_known: assert property (@(posedge clk) disable iff (!i_arst_n)
        dx.valid |-> dx.op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
                                   ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B})
        else $error("Execute holds a valid item with an unknown ALU op.");

endmodule

/* logic/insn_decode.sv */
`timescale 1ns/1ps

module insn_decode (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_ic_valid,
    input  logic [core_pkg::XLEN-1:0] i_ic_insn,
    output logic [core_pkg::XLEN-1:0] o_ic_pc,
    output logic                     o_ic_en,
    dec_exe_if.dec                   dx,
    exe_res_if.dec                   er
);
    import core_pkg::*;

    insn_u                insn;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic [XLEN-1:0]      imm_i;
    logic [XLEN-1:0]      imm_u;
    logic                 dec_ok;
    alu_op_e              dec_op;
    logic [XLEN-1:0]      dec_opb;
    logic [XLEN-1:0]      pc;

    assign insn = i_ic_insn;
    assign rs1  = insn.r_view.rs1;
    assign rs2  = insn.r_view.rs2;

    assign er.rs1 = rs1;
    assign er.rs2 = rs2;

    assign imm_i = {{(XLEN-12){insn.i_view.imm12[11]}}, insn.i_view.imm12};
    // LUI immediate spans imm12, rs1 and funct3 of the I format.
    assign imm_u = {insn.i_view.imm12, insn.i_view.rs1, insn.i_view.funct3, 12'b0};

    // Execute forward wins over the read port and its write-through.
    assign rs1_val = (dx.fwd_valid && dx.fwd_rd == rs1 && rs1 != '0) ? dx.fwd_data : er.rdata1;
    assign rs2_val = (dx.fwd_valid && dx.fwd_rd == rs2 && rs2 != '0) ? dx.fwd_data : er.rdata2;

    always_comb begin
        dec_ok  = 1'b0;
        dec_op  = ALU_ADD;
        dec_opb = imm_i;
        case (insn.r_view.opcode)
            OPC_OP: begin
                dec_opb = rs2_val;
                dec_ok  = (insn.r_view.funct7 == F7_BASE) ||
                          (insn.r_view.funct7 == F7_ALT &&
                           (insn.r_view.funct3 == F3_ADD || insn.r_view.funct3 == F3_SR));
                case (insn.r_view.funct3)
                    F3_ADD:  dec_op = (insn.r_view.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  dec_op = ALU_SLL;
                    F3_SLT:  dec_op = ALU_SLT;
                    F3_SLTU: dec_op = ALU_SLTU;
                    F3_XOR:  dec_op = ALU_XOR;
                    F3_SR:   dec_op = (insn.r_view.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:   dec_op = ALU_OR;
                    default: dec_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                dec_ok = 1'b1;
                case (insn.i_view.funct3)
                    F3_ADD:  dec_op = ALU_ADD;
                    F3_SLT:  dec_op = ALU_SLT;
                    F3_SLTU: dec_op = ALU_SLTU;
                    F3_XOR:  dec_op = ALU_XOR;
                    F3_OR:   dec_op = ALU_OR;
                    F3_AND:  dec_op = ALU_AND;
                    F3_SLL: begin
                        dec_op = ALU_SLL;
                        dec_ok = (insn.r_view.funct7 == F7_BASE);
                    end
                    default: begin
                        dec_op = (insn.r_view.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        dec_ok = (insn.r_view.funct7 == F7_BASE) ||
                                 (insn.r_view.funct7 == F7_ALT);
                    end
                endcase
            end
            OPC_LUI: begin
                dec_ok  = 1'b1;
                dec_op  = ALU_PASS_B;
                dec_opb = imm_u;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    // PC moves on every accepted word, supported or not.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= '0;
            o_ic_en <= 1'b0;
        end else begin
            o_ic_en <= 1'b1;
            if (i_ic_valid) begin
                pc <= pc + XLEN'(PC_STEP);
            end
        end
    end

    assign o_ic_pc = pc;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid <= i_ic_valid && dec_ok;
        end
    end

    always_ff @(posedge clk) begin
        dx.op  <= dec_op;
        dx.opa <= rs1_val;
        dx.opb <= dec_opb;
        dx.rd  <= insn.r_view.rd;
    end

    // A word offered during reset would be lost without a PC step.
    a_no_valid_in_reset: assert property (@(posedge clk) !i_arst_n |-> !i_ic_valid)
        else $error("Instruction valid raised during reset.");

endmodule

/* logic/core_if.sv */
`timescale 1ns/1ps

interface dec_exe_if;
    import core_pkg::*;

    logic                 valid;
    alu_op_e              op;
    logic [XLEN-1:0]      opa;
    logic [XLEN-1:0]      opb;
    logic [REG_IDX_W-1:0] rd;

    // Execute result for the item held this cycle.
    logic                 fwd_valid;
    logic [REG_IDX_W-1:0] fwd_rd;
    logic [XLEN-1:0]      fwd_data;

    modport dec (output valid, op, opa, opb, rd, input fwd_valid, fwd_rd, fwd_data);
    modport exe (input valid, op, opa, opb, rd, output fwd_valid, fwd_rd, fwd_data);
endinterface

interface exe_res_if;
    import core_pkg::*;

    logic                 valid;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      data;

    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [XLEN-1:0]      rdata1;
    logic [XLEN-1:0]      rdata2;

    modport exe (output valid, rd, data);
    modport res (input valid, rd, data, rs1, rs2, output rdata1, rdata2);
    modport dec (output rs1, rs2, input rdata1, rdata2);
endinterface

/* logic/core_pkg.sv */
package core_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = 5;
    localparam int PC_STEP   = 4;
    localparam int TP_REG    = 4;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Same instruction word seen as register and immediate formats.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } insn_u;

endpackage
